/* hdl/stream_pkg.sv */
// Shared widths and FSM state types; DEPTH_DEFAULT must stay a power of two and at least 2
`default_nettype none

package stream_pkg;

    // Default word width in bits
    localparam int DATA_W_DEFAULT = 16;

    // Default FIFO entries, power of two
    localparam int DEPTH_DEFAULT = 8;

    // Ingress receiver states
    typedef enum logic {
        IN_IDLE,
        IN_ACKED
    } ingress_state_t;

    // Egress sender states
    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_FETCH,
        OUT_OFFER,
        OUT_RELEASE
    } egress_state_t;

endpackage : stream_pkg

`default_nettype wire

/* hdl/fifo_port_if.sv */
// FIFO push/pop/status bundle; count is one bit wider than the address, DEPTH a power of two
`default_nettype none

interface fifo_port_if #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT,
    parameter int DEPTH  = stream_pkg::DEPTH_DEFAULT
) ();

    localparam int CNT_W = $clog2(DEPTH) + 1;

    // Write side
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              full;

    // Read side, pop_data valid one cycle after pop
    logic              pop;
    logic [DATA_W-1:0] pop_data;
    logic              empty;

    // Words currently stored
    logic [CNT_W-1:0]  count;

    modport writer (output push, output push_data, input full);

    modport reader (output pop, input pop_data, input empty);

    modport store (
        input  push,
        input  push_data,
        output full,
        input  pop,
        output pop_data,
        output empty,
        output count
    );

endinterface : fifo_port_if

`default_nettype wire

/* hdl/fifo_regfile.sv */
// Register-file FIFO, one-cycle read latency; push at full and pop at empty are dropped
`default_nettype none

module fifo_regfile #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT,
    parameter int DEPTH  = stream_pkg::DEPTH_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    fifo_port_if.store port
);

    localparam int PTR_W = $clog2(DEPTH);

    // Storage and pointers with an extra wrap bit
    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W:0]    wr_ptr;
    logic [PTR_W:0]    rd_ptr;
    logic [DATA_W-1:0] rd_data;

    logic              do_push;
    logic              do_pop;

    // Borrow chain for wr_ptr - rd_ptr
    logic [PTR_W-1:0]  gen;
    logic [PTR_W-1:0]  prop;
    logic [PTR_W:0]    borrow;
    logic [PTR_W:0]    diff;

    if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("fifo_regfile: DEPTH must be a power of two and at least 2");
    end

    assign port.empty = (wr_ptr == rd_ptr);
    assign port.full  = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]) &&
                        (wr_ptr[PTR_W] != rd_ptr[PTR_W]);

    assign do_push = port.push && !port.full;
    assign do_pop  = port.pop && !port.empty;

    assign borrow[0] = 1'b0;

    for (genvar i = 0; i < PTR_W; i++) begin : g_borrow
        // Borrow is born where rd has a one over a wr zero
        assign gen[i]      = rd_ptr[i] & ~wr_ptr[i];
        assign prop[i]     = ~(rd_ptr[i] ^ wr_ptr[i]);
        assign borrow[i+1] = gen[i] | (prop[i] & borrow[i]);
    end

    for (genvar i = 0; i <= PTR_W; i++) begin : g_diff
        assign diff[i] = wr_ptr[i] ^ rd_ptr[i] ^ borrow[i];
    end

    assign port.count    = diff;
    assign port.pop_data = rd_data;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= port.push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr  <= '0;
            rd_data <= '0;
        end else if (do_pop) begin
            rd_data <= mem[rd_ptr[PTR_W-1:0]];
            rd_ptr  <= rd_ptr + 1'b1;
        end
    end

endmodule : fifo_regfile

`default_nettype wire

/* hdl/handshake_ingress.sv */
// Four-phase receiver, producer synchronous to clk; no ack while the FIFO is full
`default_nettype none

module handshake_ingress #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT,
    parameter int DEPTH  = stream_pkg::DEPTH_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_req,
    input  logic [DATA_W-1:0] in_data,
    output logic              in_ack,
    fifo_port_if.writer       fifo
);
    import stream_pkg::*;

    ingress_state_t state;
    logic           accept;

    // Take the word in the same cycle the request is seen with room
    assign accept = (state == IN_IDLE) && in_req && !fifo.full;

    assign fifo.push      = accept;
    assign fifo.push_data = in_data;
    assign in_ack         = (state == IN_ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IN_IDLE;
        end else begin
            case (state)
                IN_IDLE: begin
                    if (accept) begin
                        state <= IN_ACKED;
                    end
                end
                IN_ACKED: begin
                    // Hold ack until the producer lets go of req
                    if (!in_req) begin
                        state <= IN_IDLE;
                    end
                end
                default: state <= IN_IDLE;
            endcase
        end
    end

endmodule : handshake_ingress

`default_nettype wire

/* hdl/handshake_egress.sv */
// Four-phase sender, consumer synchronous to clk; one word in flight, next pop after ack falls
`default_nettype none

module handshake_egress #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT,
    parameter int DEPTH  = stream_pkg::DEPTH_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    output logic              out_req,
    output logic [DATA_W-1:0] out_data,
    input  logic              out_ack,
    fifo_port_if.reader       fifo
);
    import stream_pkg::*;

    egress_state_t state;

    // Only fetch when idle, so the held word cannot be overwritten
    assign fifo.pop = (state == OUT_IDLE) && !fifo.empty;

    assign out_req = (state == OUT_OFFER);

    // Read register keeps the word until the next pop
    assign out_data = fifo.pop_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= OUT_IDLE;
        end else begin
            case (state)
                OUT_IDLE: begin
                    if (!fifo.empty) begin
                        state <= OUT_FETCH;
                    end
                end
                OUT_FETCH: begin
                    // pop_data is valid in this cycle
                    state <= OUT_OFFER;
                end
                OUT_OFFER: begin
                    if (out_ack) begin
                        state <= OUT_RELEASE;
                    end
                end
                OUT_RELEASE: begin
                    // Wait for the consumer to drop ack
                    if (!out_ack) begin
                        state <= OUT_IDLE;
                    end
                end
                default: state <= OUT_IDLE;
            endcase
        end
    end

endmodule : handshake_egress

`default_nettype wire

/* hdl/stream_buffer.sv */
// Req/ack word buffer, both agents synchronous to clk; level excludes the word held by egress
`default_nettype none

module stream_buffer #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT,
    parameter int DEPTH  = stream_pkg::DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,

    // Producer side
    input  logic                 in_req,
    input  logic [DATA_W-1:0]    in_data,
    output logic                 in_ack,

    // Consumer side
    output logic                 out_req,
    output logic [DATA_W-1:0]    out_data,
    input  logic                 out_ack,

    // Words held in the FIFO
    output logic [$clog2(DEPTH):0] level
);

    fifo_port_if #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) fifo_port ();

    fifo_regfile #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) fifo_regfile_i (
        .clk  (clk),
        .rst  (rst),
        .port (fifo_port)
    );

    handshake_ingress #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) handshake_ingress_i (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .fifo    (fifo_port)
    );

    handshake_egress #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) handshake_egress_i (
        .clk      (clk),
        .rst      (rst),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .fifo     (fifo_port)
    );

    assign level = fifo_port.count;

endmodule : stream_buffer

`default_nettype wire

/* verif/stream_buffer_tests.svh */
// Test and handshake driver tasks for tb_stream_buffer; every task returns 1 ns after a rising edge
`ifndef STREAM_BUFFER_TESTS_SVH
`define STREAM_BUFFER_TESTS_SVH

task automatic tick();
    @(posedge clk);
    #1;
endtask

task automatic expect_equal(string what, int expected, int actual);
    checks++;
    if (expected != actual) begin
        errors++;
        $display("** Error [%s] %s: expected %0d, actual %0d",
                 test_name, what, expected, actual);
    end
endtask

// Rest of a producer cycle once req is up
task automatic finish_send(logic [DATA_W-1:0] data);
    while (!in_ack) tick();
    exp_q.push_back(data);
    in_req = 1'b0;
    while (in_ack) tick();
endtask

task automatic send_word(logic [DATA_W-1:0] data);
    in_data = data;
    in_req  = 1'b1;
    finish_send(data);
endtask

// Consumer raises ack delay cycles after it sees req
task automatic take_word(int delay);
    logic [DATA_W-1:0] expected;
    while (!out_req) tick();
    if (exp_q.size() == 0) begin
        errors++;
        $display("[%s] out_req rose with no word left to deliver", test_name);
    end else begin
        expected = exp_q.pop_front();
        expect_equal("out_data", int'(expected), int'(out_data));
    end
    repeat (delay) tick();
    out_ack = 1'b1;
    while (out_req) tick();
    out_ack = 1'b0;
endtask

task automatic test_reset();
    test_name = "test_reset";
    expect_equal("in_ack", 0, int'(in_ack));
    expect_equal("out_req", 0, int'(out_req));
    expect_equal("level", 0, int'(level));
    expect_equal("out_data", 0, int'(out_data));
endtask

task automatic test_single();
    logic [31:0] rnd;
    int          t_push;
    int          t_req;
    test_name = "test_single";
    rnd = $urandom;
    fork
        send_word(rnd[DATA_W-1:0]);
        begin
            // in_ack rises at the push edge
            while (!in_ack) tick();
            t_push = cycle;
            while (!out_req) tick();
            t_req = cycle;
        end
    join
    expect_equal("cycles from push to out_req", 2, t_req - t_push);
    take_word(0);
    expect_equal("level", 0, int'(level));
endtask

task automatic test_fill();
    logic [31:0] rnd;
    test_name = "test_fill";
    // First word sits in the egress, the next DEPTH fill the FIFO
    for (int i = 0; i <= DEPTH; i++) begin
        rnd = $urandom;
        send_word(rnd[DATA_W-1:0]);
    end
    expect_equal("level when full", DEPTH, int'(level));
    rnd = $urandom;
    in_data = rnd[DATA_W-1:0];
    in_req  = 1'b1;
    repeat (20) begin
        tick();
        if (in_ack) begin
            errors++;
            $display("[%s] in_ack answered a request while the FIFO was full", test_name);
        end
    end
    fork
        take_word(3);
        finish_send(rnd[DATA_W-1:0]);
    join
    repeat (DEPTH + 1) take_word(0);
    expect_equal("words left", 0, exp_q.size());
    expect_equal("level", 0, int'(level));
endtask

task automatic test_stream();
    logic [31:0] rnd;
    test_name = "test_stream";
    fork
        for (int i = 0; i < N_STREAM; i++) begin
            repeat ($urandom_range(4)) tick();
            rnd = $urandom;
            send_word(rnd[DATA_W-1:0]);
        end
        for (int i = 0; i < N_STREAM; i++) begin
            take_word($urandom_range(6));
        end
    join
    expect_equal("words left", 0, exp_q.size());
endtask

task automatic test_level();
    test_name     = "test_level";
    level_samples = 0;
    level_watch   = 1'b1;
    test_stream();
    level_watch   = 1'b0;
    if (level_samples == 0) begin
        errors++;
        $display("[test_level] no level sample was taken during the stream");
    end
endtask

`endif

/* verif/tb_stream_buffer.sv */
// Testbench for stream_buffer at package defaults; producer and consumer driven synchronous to clk
`default_nettype none

module tb_stream_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    import stream_pkg::*;

    localparam int DATA_W   = DATA_W_DEFAULT;
    localparam int DEPTH    = DEPTH_DEFAULT;
    localparam int N_STREAM = 200;
    // Reset, single, fill, drain and stream, in cycles
    localparam int WORST_CYCLES = 8 + 20 + (DEPTH + 1) * 6 + 20 + (DEPTH + 2) * 10 + N_STREAM * 20;

    logic                   clk;
    logic                   rst;
    logic                   in_req;
    logic [DATA_W-1:0]      in_data;
    logic                   in_ack;
    logic                   out_req;
    logic [DATA_W-1:0]      out_data;
    logic                   out_ack;
    logic [$clog2(DEPTH):0] level;

    int          errors;
    int          checks;
    int          cycle;
    string       test_name;

    // Reference model of the data order and the occupancy
    logic [DATA_W-1:0] exp_q[$];
    int                accepted;
    int                completed;
    int                model_level;
    int                level_samples;
    bit                level_watch;
    logic              in_ack_q;
    logic              out_ack_q;

    `include "stream_buffer_tests.svh"

    stream_buffer #(
        .DATA_W (DATA_W),
        .DEPTH  (DEPTH)
    ) stream_buffer_i (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .level    (level)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Occupancy from the handshakes, sampled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (in_ack && !in_ack_q) accepted++;
            if (!out_ack && out_ack_q) completed++;
            model_level = accepted - completed - ((out_req || out_ack) ? 1 : 0);
            // Egress phase is known while it offers or awaits ack release, or when nothing is left
            if (level_watch && (out_req || out_ack || accepted == completed)) begin
                level_samples++;
                checks++;
                if (int'(level) != model_level || int'(level) > DEPTH) begin
                    errors++;
                    $display("** Error [test_level] level: expected %0d, actual %0d",
                             model_level, level);
                end
            end
        end
        in_ack_q  = in_ack;
        out_ack_q = out_ack;
    end

    initial begin
        void'($urandom(32'hc5db3c09));
        rst       = 1'b1;
        in_req    = 1'b0;
        in_data   = '0;
        out_ack   = 1'b0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_single();
        test_fill();
        test_level();
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (4 * WORST_CYCLES) @(posedge clk);
        errors++;
        $display("Timeout: the tests did not finish within %0d cycles", 4 * WORST_CYCLES);
        $display("Errors: %0d in %0d checks", errors, checks);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_stream_buffer

`default_nettype wire

/* stream_buffer.f */
hdl/stream_pkg.sv
hdl/fifo_port_if.sv
hdl/fifo_regfile.sv
hdl/handshake_ingress.sv
hdl/handshake_egress.sv
hdl/stream_buffer.sv
+incdir+verif
verif/tb_stream_buffer.sv

/* Makefile */
TOP := tb_stream_buffer

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): stream_buffer.f hdl/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --timescale 1ns/100ps -f stream_buffer.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
